// File: rtl/mp_pkg.sv
`default_nettype none

package mp_pkg;

	localparam int ADDR_W = 8;
	localparam int DATA_W = 32;
	localparam int OP_W = 16;
	localparam int RES_W = 16;
	localparam int N_DIGITS = 4;
	localparam int N_CELLS = N_DIGITS * N_DIGITS;
	localparam int ACC_W = 22; // headroom for the raw partial sum
	localparam int FP4_MAX_ABS = 576; // four terms of 3*3 shifted by 4

	// bit positions inside one operand
	localparam int INT8_SIGN = 7;
	localparam int FP4_SIGN = 3;
	localparam int FP4_EXP_LSB = 1;
	localparam int FP4_MANT = 0;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [1:0] digit_t;
	typedef logic [3:0] pprod_t;
	typedef logic [3:0] shift_t;
	typedef logic signed [RES_W-1:0] result_t;
	typedef logic [3:0] fp4_t;
	typedef logic [OP_W-1:0] operand_t;

	localparam addr_t ADDR_MODE = 8'h00;
	localparam addr_t ADDR_OPA = 8'h04;
	localparam addr_t ADDR_OPB = 8'h08;
	localparam addr_t ADDR_RESULT = 8'h0C;
	localparam addr_t ADDR_STATUS = 8'h10;

	typedef enum logic {
		MODE_INT8 = 1'b0,
		MODE_FP4 = 1'b1
	} mode_e;

	// one operand split into digit positions
	typedef struct packed {
		digit_t [N_DIGITS-1:0] digit;
		shift_t [N_DIGITS-1:0] share; // this operand's part of the term shift
		logic [N_DIGITS-1:0] sign;
	} unpacked_s;

	// cell c = i*N_DIGITS + j, a-digit i times b-digit j
	typedef struct packed {
		pprod_t [N_CELLS-1:0] prod;
		shift_t [N_CELLS-1:0] shift;
		logic [N_CELLS-1:0] neg;
	} term_s;

endpackage

`default_nettype wire

// File: rtl/apb_regs.sv
`default_nettype none

module apb_regs (
	input  wire                    clk_i,
	input  wire                    arst_n_i,
	input  wire                    psel_i,
	input  wire                    penable_i,
	input  wire                    pwrite_i,
	input  wire mp_pkg::addr_t     paddr_i,
	input  wire mp_pkg::data_t     pwdata_i,
	output mp_pkg::data_t          prdata_o,
	output logic                   pready_o,
	output logic                   pslverr_o,
	input  wire                    result_valid_i,
	input  wire mp_pkg::result_t   result_i,
	output mp_pkg::mode_e          mode_o,
	output mp_pkg::operand_t       opa_o,
	output mp_pkg::operand_t       opb_o,
	output logic                   launch_o
);

	logic access;
	logic wr_en;
	logic rd_en;
	logic mapped;
	logic read_only;
	logic wr_ok;
	mp_pkg::mode_e mode_q;
	mp_pkg::operand_t opa_q;
	mp_pkg::operand_t opb_q;
	mp_pkg::result_t result_q;
	logic done_q;
	logic [1:0] inflight_q; // launched but not yet landed

	assign access = psel_i & penable_i;
	assign wr_en = access & pwrite_i;
	assign rd_en = access & ~pwrite_i;

	assign mapped = paddr_i inside {mp_pkg::ADDR_MODE, mp_pkg::ADDR_OPA, mp_pkg::ADDR_OPB,
		mp_pkg::ADDR_RESULT, mp_pkg::ADDR_STATUS};
	assign read_only = paddr_i inside {mp_pkg::ADDR_RESULT, mp_pkg::ADDR_STATUS};
	assign wr_ok = wr_en & mapped & ~read_only;

	assign pready_o = 1'b1; // zero wait states
	assign pslverr_o = access & (~mapped | (pwrite_i & read_only));

	assign launch_o = wr_ok & (paddr_i == mp_pkg::ADDR_OPB);

	// new OPB goes straight to the array in the launching cycle
	assign opb_o = launch_o ? pwdata_i[mp_pkg::OP_W-1:0] : opb_q;
	assign opa_o = opa_q;
	assign mode_o = mode_q;

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			mode_q <= mp_pkg::MODE_INT8;
			opa_q <= '0;
			opb_q <= '0;
		end else if (wr_ok) begin
			case (paddr_i)
				mp_pkg::ADDR_MODE: mode_q <= mp_pkg::mode_e'(pwdata_i[0]);
				mp_pkg::ADDR_OPA: opa_q <= pwdata_i[mp_pkg::OP_W-1:0];
				mp_pkg::ADDR_OPB: opb_q <= pwdata_i[mp_pkg::OP_W-1:0];
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			result_q <= '0;
			done_q <= 1'b0;
			inflight_q <= '0;
		end else begin
			if (result_valid_i) begin
				result_q <= result_i; // results land in launch order
			end
			case ({launch_o, result_valid_i})
				2'b10: inflight_q <= inflight_q + 2'd1;
				2'b01: inflight_q <= inflight_q - 2'd1;
				default: ;
			endcase
			if (launch_o) begin
				done_q <= 1'b0;
			end else if (result_valid_i && inflight_q == 2'd1) begin
				done_q <= 1'b1; // last outstanding item
			end
		end
	end

	always_comb begin
		prdata_o = '0;
		if (rd_en) begin
			case (paddr_i)
				mp_pkg::ADDR_MODE: prdata_o = mp_pkg::data_t'(mode_q);
				mp_pkg::ADDR_OPA: prdata_o = mp_pkg::data_t'(opa_q);
				mp_pkg::ADDR_OPB: prdata_o = mp_pkg::data_t'(opb_q);
				mp_pkg::ADDR_RESULT: prdata_o = mp_pkg::data_t'($unsigned(result_q));
				mp_pkg::ADDR_STATUS: prdata_o = mp_pkg::data_t'(done_q);
				default: prdata_o = '0;
			endcase
		end
	end

	penable_needs_psel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		penable_i |-> psel_i);

	// the two pipeline stages hold at most two items
	inflight_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		inflight_q <= 2'd2);

endmodule

`default_nettype wire

// File: rtl/operand_unpack.sv
`default_nettype none

module operand_unpack (
	input  wire mp_pkg::operand_t  op_i,
	input  wire mp_pkg::mode_e     mode_i,
	output mp_pkg::unpacked_s      unp_o
);

	logic [7:0] int_mag;
	mp_pkg::fp4_t [mp_pkg::N_DIGITS-1:0] elem;
	logic [mp_pkg::N_DIGITS-1:0] exp_nz;
	logic [1:0] exp_f [mp_pkg::N_DIGITS];

	// -128 comes out as 128, which still fits 8 unsigned bits
	assign int_mag = op_i[mp_pkg::INT8_SIGN] ? ~op_i[7:0] + 8'd1 : op_i[7:0];

	assign elem = op_i;

	always_comb begin
		for (int k = 0; k < mp_pkg::N_DIGITS; k++) begin
			exp_f[k] = elem[k][mp_pkg::FP4_EXP_LSB +: 2];
			exp_nz[k] = exp_f[k] != 2'd0;
		end
	end

	always_comb begin
		unp_o = '0;
		for (int k = 0; k < mp_pkg::N_DIGITS; k++) begin
			if (mode_i == mp_pkg::MODE_INT8) begin
				unp_o.digit[k] = int_mag[2*k +: 2];
				unp_o.share[k] = mp_pkg::shift_t'(2 * k); // radix-4 weight
				unp_o.sign[k] = op_i[mp_pkg::INT8_SIGN];
			end else begin
				// implicit bit, absent for subnormals
				unp_o.digit[k] = {exp_nz[k], elem[k][mp_pkg::FP4_MANT]};
				// effective exponent minus one, e=0 behaves as e=1
				if (exp_nz[k]) begin
					unp_o.share[k] = mp_pkg::shift_t'(exp_f[k] - 2'd1);
				end else begin
					unp_o.share[k] = '0;
				end
				unp_o.sign[k] = elem[k][mp_pkg::FP4_SIGN];
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/digit_mul_array.sv
`default_nettype none

module digit_mul_array (
	input  wire                      clk_i,
	input  wire                      arst_n_i,
	input  wire mp_pkg::unpacked_s   a_i,
	input  wire mp_pkg::unpacked_s   b_i,
	input  wire mp_pkg::mode_e       mode_i,
	input  wire                      launch_i,
	output mp_pkg::term_s            terms_o,
	output logic                     stage1_valid_o
);

	mp_pkg::term_s terms_d;

	// 2x2 product from two gated rows
	function automatic mp_pkg::pprod_t mul2(input mp_pkg::digit_t x, input mp_pkg::digit_t y);
		mp_pkg::pprod_t row0;
		mp_pkg::pprod_t row1;
		row0 = y[0] ? {2'b00, x} : 4'd0;
		row1 = y[1] ? {1'b0, x, 1'b0} : 4'd0;
		return row0 + row1;
	endfunction

	always_comb begin
		logic live;
		mp_pkg::digit_t da;
		mp_pkg::digit_t db;
		terms_d = '0;
		for (int i = 0; i < mp_pkg::N_DIGITS; i++) begin
			for (int j = 0; j < mp_pkg::N_DIGITS; j++) begin
				live = (mode_i == mp_pkg::MODE_INT8) || (i == j); // fp4 uses the diagonal
				da = live ? a_i.digit[i] : 2'd0;
				db = live ? b_i.digit[j] : 2'd0;
				terms_d.prod[i*mp_pkg::N_DIGITS + j] = mul2(da, db);
				if (live) begin
					terms_d.shift[i*mp_pkg::N_DIGITS + j] = a_i.share[i] + b_i.share[j];
					terms_d.neg[i*mp_pkg::N_DIGITS + j] = a_i.sign[i] ^ b_i.sign[j];
				end
			end
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			stage1_valid_o <= 1'b0;
		end else begin
			stage1_valid_o <= launch_i;
		end
	end

	// a new item may follow in the very next cycle
	always_ff @(posedge clk_i) begin
		if (launch_i) begin
			terms_o <= terms_d;
		end
	end

endmodule

`default_nettype wire

// File: rtl/term_reduce.sv
`default_nettype none

module term_reduce (
	input  wire                    clk_i,
	input  wire                    arst_n_i,
	input  wire mp_pkg::term_s     terms_i,
	input  wire                    stage1_valid_i,
	input  wire mp_pkg::mode_e     mode_i,
	output mp_pkg::result_t        result_o,
	output logic                   result_valid_o
);

	logic signed [mp_pkg::ACC_W-1:0] mag [mp_pkg::N_CELLS];
	logic signed [mp_pkg::ACC_W-1:0] sterm [mp_pkg::N_CELLS];
	logic signed [mp_pkg::ACC_W-1:0] sum;

	// place each digit product at its weight
	always_comb begin
		for (int c = 0; c < mp_pkg::N_CELLS; c++) begin
			mag[c] = {{(mp_pkg::ACC_W - $bits(mp_pkg::pprod_t)){1'b0}}, terms_i.prod[c]}
				<< terms_i.shift[c];
			sterm[c] = terms_i.neg[c] ? -mag[c] : mag[c];
		end
	end

	// exact sum, no rounding anywhere
	always_comb begin
		sum = '0;
		for (int c = 0; c < mp_pkg::N_CELLS; c++) begin
			sum = sum + sterm[c];
		end
	end

	always_ff @(posedge clk_i or negedge arst_n_i) begin
		if (!arst_n_i) begin
			result_valid_o <= 1'b0;
		end else begin
			result_valid_o <= stage1_valid_i;
		end
	end

	always_ff @(posedge clk_i) begin
		if (stage1_valid_i) begin
			result_o <= mp_pkg::result_t'(sum); // int8 range is +-16384
		end
	end

	// unpack and array must keep fp4 terms inside the format's range
	fp4_sum_range: assert property (@(posedge clk_i) disable iff (!arst_n_i)
		(stage1_valid_i && mode_i == mp_pkg::MODE_FP4) |->
		(sum <= mp_pkg::FP4_MAX_ABS && sum >= -mp_pkg::FP4_MAX_ABS));

endmodule

`default_nettype wire

// File: rtl/mp_mul_top.sv
`default_nettype none

module mp_mul_top (
	input  wire                 clk_i,
	input  wire                 arst_n_i,
	input  wire                 psel_i,
	input  wire                 penable_i,
	input  wire                 pwrite_i,
	input  wire mp_pkg::addr_t  paddr_i,
	input  wire mp_pkg::data_t  pwdata_i,
	output mp_pkg::data_t       prdata_o,
	output logic                pready_o,
	output logic                pslverr_o
);

	mp_pkg::mode_e mode;
	mp_pkg::operand_t opa;
	mp_pkg::operand_t opb;
	logic launch;
	mp_pkg::unpacked_s unp_a;
	mp_pkg::unpacked_s unp_b;
	mp_pkg::term_s terms;
	logic stage1_valid;
	mp_pkg::result_t result;
	logic result_valid;

	apb_regs u_apb_regs (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.psel_i         (psel_i),
		.penable_i      (penable_i),
		.pwrite_i       (pwrite_i),
		.paddr_i        (paddr_i),
		.pwdata_i       (pwdata_i),
		.prdata_o       (prdata_o),
		.pready_o       (pready_o),
		.pslverr_o      (pslverr_o),
		.result_valid_i (result_valid),
		.result_i       (result),
		.mode_o         (mode),
		.opa_o          (opa),
		.opb_o          (opb),
		.launch_o       (launch)
	);

	operand_unpack u_unpack_a (
		.op_i   (opa),
		.mode_i (mode),
		.unp_o  (unp_a)
	);

	operand_unpack u_unpack_b (
		.op_i   (opb),
		.mode_i (mode),
		.unp_o  (unp_b)
	);

	digit_mul_array u_mul_array (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.a_i            (unp_a),
		.b_i            (unp_b),
		.mode_i         (mode),
		.launch_i       (launch),
		.terms_o        (terms),
		.stage1_valid_o (stage1_valid)
	);

	term_reduce u_term_reduce (
		.clk_i          (clk_i),
		.arst_n_i       (arst_n_i),
		.terms_i        (terms),
		.stage1_valid_i (stage1_valid),
		.mode_i         (mode),
		.result_o       (result),
		.result_valid_o (result_valid)
	);

endmodule

`default_nettype wire

// File: test/tb_mp_mul.sv
`default_nettype none

module tb_mp_mul;

	localparam int HALF_PERIOD = 20;
	localparam int DRIVE_DLY = 1;
	localparam int N_RANDOM = 200;
	localparam int N_CASES = 25 + N_RANDOM + 6 + N_RANDOM;
	localparam int CASE_CYCLES = 10; // two writes, three reads at two cycles each
	localparam int OTHER_CYCLES = 150;
	localparam int TIMEOUT_CYCLES = 2 * (N_CASES * CASE_CYCLES + OTHER_CYCLES);
	localparam int MAX_POLLS = 4;

	logic clk_i = 1'b0;
	logic arst_n_i;
	logic psel_i;
	logic penable_i;
	logic pwrite_i;
	mp_pkg::addr_t paddr_i;
	mp_pkg::data_t pwdata_i;
	mp_pkg::data_t prdata_o;
	logic pready_o;
	logic pslverr_o;

	int seed = 32'h19fd;
	int value_errors = 0;
	int other_errors = 0;
	int result_checks = 0;
	int cycles = 0;
	mp_pkg::mode_e cur_mode;
	mp_pkg::result_t exp_result;
	logic expect_result = 1'b0;
	logic bus_err;
	mp_pkg::data_t rd_data;
	mp_pkg::data_t rnd;
	mp_pkg::operand_t a_val;
	mp_pkg::operand_t b_val;
	logic [7:0] corners [5];

	mp_mul_top UUT (
		.clk_i     (clk_i),
		.arst_n_i  (arst_n_i),
		.psel_i    (psel_i),
		.penable_i (penable_i),
		.pwrite_i  (pwrite_i),
		.paddr_i   (paddr_i),
		.pwdata_i  (pwdata_i),
		.prdata_o  (prdata_o),
		.pready_o  (pready_o),
		.pslverr_o (pslverr_o)
	);

	always #HALF_PERIOD clk_i = ~clk_i;

	always @(posedge clk_i) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the test sequence did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

	// int8 is a plain signed product
	// fp4 sums sig_a*sig_b at 2^(eff_a+eff_b-2)
	function automatic mp_pkg::result_t expected_result(input mp_pkg::mode_e mode,
		input mp_pkg::operand_t a, input mp_pkg::operand_t b);
		int acc;
		int ia;
		int ib;
		int sig_a;
		int sig_b;
		int eff_a;
		int eff_b;
		int term;
		mp_pkg::fp4_t ea;
		mp_pkg::fp4_t eb;
		acc = 0;
		if (mode == mp_pkg::MODE_INT8) begin
			ia = int'($signed(a[7:0]));
			ib = int'($signed(b[7:0]));
			acc = ia * ib;
		end else begin
			for (int k = 0; k < mp_pkg::N_DIGITS; k++) begin
				ea = a[4*k +: 4];
				eb = b[4*k +: 4];
				sig_a = (ea[2:1] == 2'd0) ? int'(ea[0]) : 2 + int'(ea[0]);
				sig_b = (eb[2:1] == 2'd0) ? int'(eb[0]) : 2 + int'(eb[0]);
				eff_a = (ea[2:1] == 2'd0) ? 1 : int'(ea[2:1]);
				eff_b = (eb[2:1] == 2'd0) ? 1 : int'(eb[2:1]);
				term = (sig_a * sig_b) << (eff_a + eff_b - 2);
				if (ea[3] ^ eb[3]) begin
					term = -term;
				end
				acc = acc + term;
			end
		end
		return mp_pkg::result_t'(acc);
	endfunction

	// every RESULT read is compared here
	always @(negedge clk_i) begin
		if (psel_i && penable_i) begin
			assert (pready_o === 1'b1) else begin
				$display("ERROR t=%0t pready_o expected 1 got %b", $time, pready_o);
				value_errors++;
			end
			if (!pwrite_i && paddr_i == mp_pkg::ADDR_RESULT && expect_result) begin
				result_checks++;
				assert (prdata_o === {16'h0, exp_result}) else begin
					$display("ERROR t=%0t prdata_o(RESULT) expected %h got %h", $time,
						{16'h0, exp_result}, prdata_o);
					value_errors++;
				end
			end
		end
	end

	task automatic check_value(input string name, input mp_pkg::data_t exp,
		input mp_pkg::data_t act);
		assert (act === exp) else begin
			$display("ERROR t=%0t %s expected %h got %h", $time, name, exp, act);
			value_errors++;
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic act);
		assert (act === exp) else begin
			$display("ERROR t=%0t %s expected %b got %b", $time, name, exp, act);
			value_errors++;
		end
	endtask

	// called right after a rising edge plus the drive delay
	task automatic apb_write(input mp_pkg::addr_t addr, input mp_pkg::data_t data,
		output logic err);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b1;
		paddr_i = addr;
		pwdata_i = data;
		@(posedge clk_i);
		#DRIVE_DLY;
		penable_i = 1'b1;
		@(negedge clk_i);
		err = pslverr_o;
		@(posedge clk_i);
		#DRIVE_DLY;
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic apb_read(input mp_pkg::addr_t addr, output mp_pkg::data_t data,
		output logic err);
		psel_i = 1'b1;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = addr;
		@(posedge clk_i);
		#DRIVE_DLY;
		penable_i = 1'b1;
		@(negedge clk_i);
		data = prdata_o;
		err = pslverr_o;
		@(posedge clk_i);
		#DRIVE_DLY;
		psel_i = 1'b0;
		penable_i = 1'b0;
	endtask

	task automatic read_expect(input mp_pkg::addr_t addr, input string name,
		input mp_pkg::data_t exp);
		mp_pkg::data_t data;
		logic err;
		apb_read(addr, data, err);
		check_value(name, exp, data);
		check_flag("pslverr_o", 1'b0, err);
	endtask

	task automatic read_result(input mp_pkg::result_t exp);
		mp_pkg::data_t data;
		logic err;
		exp_result = exp;
		expect_result = 1'b1;
		apb_read(mp_pkg::ADDR_RESULT, data, err);
		expect_result = 1'b0;
		check_flag("pslverr_o", 1'b0, err);
	endtask

	task automatic write_ok(input mp_pkg::addr_t addr, input mp_pkg::data_t data);
		logic err;
		apb_write(addr, data, err);
		check_flag("pslverr_o", 1'b0, err);
	endtask

	task automatic set_mode(input mp_pkg::mode_e mode);
		write_ok(mp_pkg::ADDR_MODE, mp_pkg::data_t'(mode));
		cur_mode = mode;
	endtask

	task automatic wait_done();
		mp_pkg::data_t st;
		logic err;
		int polls;
		polls = 0;
		st = '0;
		while (st[0] !== 1'b1 && polls < MAX_POLLS) begin
			apb_read(mp_pkg::ADDR_STATUS, st, err);
			polls++;
		end
		assert (st[0] === 1'b1) else begin
			$display("done never came up within %0d status reads at %0t", MAX_POLLS, $time);
			other_errors++;
		end
	endtask

	task automatic run_case(input mp_pkg::operand_t a, input mp_pkg::operand_t b);
		write_ok(mp_pkg::ADDR_OPA, {16'h0, a});
		write_ok(mp_pkg::ADDR_OPB, {16'h0, b});
		read_expect(mp_pkg::ADDR_STATUS, "prdata_o(STATUS)", 32'd0); // still in flight
		wait_done();
		read_result(expected_result(cur_mode, a, b));
	endtask

	// status read sampled just after the second edge after launch
	task automatic check_latency(input mp_pkg::operand_t a, input mp_pkg::operand_t b);
		write_ok(mp_pkg::ADDR_OPA, {16'h0, a});
		write_ok(mp_pkg::ADDR_OPB, {16'h0, b});
		@(posedge clk_i);
		#DRIVE_DLY;
		read_expect(mp_pkg::ADDR_STATUS, "prdata_o(STATUS)", 32'd1);
		read_result(expected_result(cur_mode, a, b));
	endtask

	initial begin
		corners[0] = 8'h00;
		corners[1] = 8'h01;
		corners[2] = 8'hFF;
		corners[3] = 8'h7F;
		corners[4] = 8'h80;
		arst_n_i = 1'b0;
		psel_i = 1'b0;
		penable_i = 1'b0;
		pwrite_i = 1'b0;
		paddr_i = '0;
		pwdata_i = '0;
		cur_mode = mp_pkg::MODE_INT8;
		repeat (2) @(posedge clk_i);
		#DRIVE_DLY;
		arst_n_i = 1'b1;

		read_expect(mp_pkg::ADDR_MODE, "prdata_o(MODE)", 32'd0);
		read_expect(mp_pkg::ADDR_OPA, "prdata_o(OPA)", 32'd0);
		read_expect(mp_pkg::ADDR_OPB, "prdata_o(OPB)", 32'd0);
		read_expect(mp_pkg::ADDR_STATUS, "prdata_o(STATUS)", 32'd0);
		read_result('0);

		set_mode(mp_pkg::MODE_INT8);
		for (int i = 0; i < 5; i++) begin
			for (int j = 0; j < 5; j++) begin
				run_case({8'h00, corners[i]}, {8'h00, corners[j]});
			end
		end
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $random(seed);
			a_val = rnd[15:0];
			rnd = $random(seed);
			b_val = rnd[15:0];
			run_case(a_val, b_val);
		end

		// mode readback and rejected accesses that leave every register alone
		set_mode(mp_pkg::MODE_FP4);
		read_expect(mp_pkg::ADDR_MODE, "prdata_o(MODE)", 32'd1);
		set_mode(mp_pkg::MODE_INT8);
		read_expect(mp_pkg::ADDR_MODE, "prdata_o(MODE)", 32'd0);
		apb_write(8'h14, 32'hFFFF_FFFF, bus_err);
		check_flag("pslverr_o", 1'b1, bus_err);
		apb_write(8'h05, 32'h0000_0001, bus_err);
		check_flag("pslverr_o", 1'b1, bus_err);
		apb_write(mp_pkg::ADDR_RESULT, 32'h0000_1234, bus_err);
		check_flag("pslverr_o", 1'b1, bus_err);
		apb_write(mp_pkg::ADDR_STATUS, 32'h0000_0000, bus_err);
		check_flag("pslverr_o", 1'b1, bus_err);
		apb_read(8'h40, rd_data, bus_err);
		check_flag("pslverr_o", 1'b1, bus_err);
		check_value("prdata_o(unmapped)", 32'd0, rd_data);
		read_expect(mp_pkg::ADDR_MODE, "prdata_o(MODE)", 32'd0);
		read_expect(mp_pkg::ADDR_OPA, "prdata_o(OPA)", {16'h0, a_val});
		read_expect(mp_pkg::ADDR_OPB, "prdata_o(OPB)", {16'h0, b_val});
		read_expect(mp_pkg::ADDR_STATUS, "prdata_o(STATUS)", 32'd1);
		read_result(expected_result(cur_mode, a_val, b_val));

		check_latency(16'h0080, 16'h00F3);

		// two launches in adjacent transfers leave only the second result
		write_ok(mp_pkg::ADDR_OPA, 32'h0000_00B5);
		write_ok(mp_pkg::ADDR_OPB, 32'h0000_0013);
		write_ok(mp_pkg::ADDR_OPB, 32'h0000_0081);
		read_expect(mp_pkg::ADDR_STATUS, "prdata_o(STATUS)", 32'd0);
		wait_done();
		read_result(expected_result(cur_mode, 16'h00B5, 16'h0081));

		set_mode(mp_pkg::MODE_FP4);
		run_case(16'h1111, 16'h1111); // subnormals only
		run_case(16'h1031, 16'h7151);
		run_case(16'h7777, 16'h7777); // largest magnitude
		run_case(16'hFFFF, 16'h7777);
		run_case(16'hF7F7, 16'h7777); // signs cancel
		run_case(16'h9C3A, 16'h5E82);
		for (int n = 0; n < N_RANDOM; n++) begin
			rnd = $random(seed);
			a_val = rnd[15:0];
			rnd = $random(seed);
			b_val = rnd[15:0];
			run_case(a_val, b_val);
		end
		check_latency(16'hB5E3, 16'h2F71);

		@(posedge clk_i);
		$display("errors: %0d wrong values, %0d other failures, %0d results compared",
			value_errors, other_errors, result_checks);
		if (value_errors == 0 && other_errors == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tb.f
rtl/mp_pkg.sv
rtl/apb_regs.sv
rtl/operand_unpack.sv
rtl/digit_mul_array.sv
rtl/term_reduce.sv
rtl/mp_mul_top.sv
test/tb_mp_mul.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= tb_mp_mul
FLIST ?= tb.f
BUILD_DIR ?= obj_dir
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing --assert
PASS_MSG ?= Test passed

SRCS := $(wildcard rtl/*.sv) $(wildcard test/*.sv)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

$(SIM_BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FLIST)

sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
